// ==== include/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// instruction word address width.
`define FETCH_ADDR_W 8

// instruction word width.
`define FETCH_INST_W 32

// global history length.
`define FETCH_GH_W 4

// pattern table index, one entry per word address.
`define FETCH_PAT_W `FETCH_ADDR_W

// first address fetched after reset.
`define FETCH_PC_INIT 0

`endif

// ==== logic/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

	// opcode field, top four bits of the word.
	typedef enum logic [3:0] {
		op_plain  = 4'h0,
		op_jump   = 4'h1,
		op_branch = 4'h2,
		op_jreg   = 4'h3
	} opcode_t;

	// word address into the instruction memory.
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// raw instruction word.
	typedef logic [`FETCH_INST_W-1:0] inst_t;

	// gshare table index.
	typedef logic [`FETCH_PAT_W-1:0] pattern_t;

	// two-bit predictor entry.
	// bit 1 is the predicted direction, bit 0 the confidence.
	typedef logic [1:0] counter_t;

	// global history register.
	typedef logic [`FETCH_GH_W-1:0] history_t;

endpackage

// ==== logic/inst_decode.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module inst_decode (
	input  fetch_pkg::inst_t inst,
	output logic             is_jump,
	output logic             is_branch,
	output logic             is_jreg,
	output fetch_pkg::addr_t target
);
	import fetch_pkg::*;

	opcode_t opcode;

	assign opcode = opcode_t'(inst[`FETCH_INST_W-1 -: 4]);

	// jump and branch targets sit in the low bits.
	assign target = inst[`FETCH_ADDR_W-1:0];

	always_comb begin
		is_jump = 1'b0;
		is_branch = 1'b0;
		is_jreg = 1'b0;
		case (opcode)
			op_jump: begin
				is_jump = 1'b1;
			end
			op_branch: begin
				is_branch = 1'b1;
			end
			op_jreg: begin
				is_jreg = 1'b1;
			end
			default: begin
				// plain and unknown opcodes fall through sequentially.
				is_jump = 1'b0;
			end
		endcase
	end

endmodule

// ==== logic/branch_predictor.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module branch_predictor (
	input  logic                clk,
	input  logic                reset,
	input  logic                lookup_en,
	input  fetch_pkg::addr_t    lookup_addr,
	output fetch_pkg::counter_t pred_counter,
	output fetch_pkg::pattern_t pred_pattern,
	input  logic                commit,
	input  fetch_pkg::pattern_t commit_pattern,
	input  logic                commit_failure,
	input  fetch_pkg::counter_t commit_counter
);
	import fetch_pkg::*;

	counter_t pht [2**`FETCH_PAT_W];
	history_t gh;
	pattern_t pattern;
	logic     taken;
	counter_t counter_updated;

	// history folded into the upper index bits.
	assign pattern = pattern_t'(lookup_addr) ^
		{gh, {(`FETCH_PAT_W-`FETCH_GH_W){1'b0}}};

	// actual outcome from the prediction and the miss flag.
	assign taken = commit_counter[1] ^ commit_failure;

	// direction only flips on a miss at low confidence.
	assign counter_updated[1] = commit_counter[1] ^ (commit_failure & ~commit_counter[0]);
	assign counter_updated[0] = ~commit_failure;

	always_ff @(posedge clk) begin
		if (reset) begin
			gh <= '0;
			pht <= '{default: '0};
		end else if (commit) begin
			gh <= {gh[`FETCH_GH_W-2:0], taken};
			pht[commit_pattern] <= counter_updated;
		end
	end

	// lookup result travels with the fetched word.
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			pred_counter <= pht[pattern];
			pred_pattern <= pattern;
		end
	end

endmodule

// ==== logic/inst_fetch.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module inst_fetch (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                busy,
	input  logic                imem_we,
	input  fetch_pkg::addr_t    imem_waddr,
	input  fetch_pkg::inst_t    imem_wdata,
	input  fetch_pkg::addr_t    return_addr,
	input  logic                redirect,
	input  fetch_pkg::addr_t    redirect_addr,
	input  logic                is_jump,
	input  logic                is_branch,
	input  logic                is_jreg,
	input  fetch_pkg::addr_t    target,
	input  fetch_pkg::counter_t pred_counter,
	output logic                inst_valid,
	output fetch_pkg::inst_t    inst_bits,
	output fetch_pkg::addr_t    inst_pc,
	output logic                lookup_en,
	output fetch_pkg::addr_t    lookup_addr,
	output logic                branch_issue
);
	import fetch_pkg::*;

	inst_t imem [2**`FETCH_ADDR_W];
	addr_t pc;
	addr_t fetch_addr;
	logic  load;

	// load port, used by the testbench while reset is held.
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_waddr] <= imem_wdata;
		end
	end

	// an empty output register never waits for stall.
	assign load = ~busy & (~inst_valid | ~stall);
	assign branch_issue = inst_valid & ~stall & is_branch;

	always_comb begin
		if (reset) begin
			fetch_addr = addr_t'(`FETCH_PC_INIT);
		end else if (redirect) begin
			fetch_addr = redirect_addr;
		end else if (inst_valid & (is_jump | (is_branch & pred_counter[1]))) begin
			fetch_addr = target;
		end else if (inst_valid & is_jreg) begin
			fetch_addr = return_addr;
		end else begin
			fetch_addr = pc;
		end
	end

	assign lookup_en = load;
	assign lookup_addr = fetch_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= addr_t'(`FETCH_PC_INIT);
			inst_valid <= 1'b0;
		end else if (load) begin
			pc <= addr_t'(fetch_addr + 1'b1);
			// nothing more issues until the branch resolves.
			inst_valid <= ~branch_issue;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset && load) begin
			inst_bits <= imem[fetch_addr];
			inst_pc <= fetch_addr;
		end
	end

endmodule

// ==== logic/branch_resolve.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module branch_resolve (
	input  logic                clk,
	input  logic                reset,
	input  logic                branch_issue,
	input  fetch_pkg::addr_t    inst_pc,
	input  fetch_pkg::addr_t    target,
	input  fetch_pkg::counter_t pred_counter,
	input  fetch_pkg::pattern_t pred_pattern,
	input  logic                resolve_ack,
	input  logic                resolve_taken,
	output logic                busy,
	output logic                resolve_req,
	output fetch_pkg::addr_t    resolve_pc,
	output logic                commit,
	output fetch_pkg::pattern_t commit_pattern,
	output logic                commit_failure,
	output fetch_pkg::counter_t commit_counter,
	output logic                redirect,
	output fetch_pkg::addr_t    redirect_addr
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_wait_ack,
		s_wait_release
	} state_t;

	state_t   state;
	addr_t    pc_q;
	addr_t    target_q;
	counter_t counter_q;
	pattern_t pattern_q;
	logic     taken_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			commit <= 1'b0;
			redirect <= 1'b0;
		end else begin
			commit <= 1'b0;
			redirect <= 1'b0;
			case (state)
				s_idle: begin
					if (branch_issue) begin
						state <= s_wait_ack;
					end
				end
				s_wait_ack: begin
					if (resolve_ack) begin
						commit <= 1'b1;
						state <= s_wait_release;
					end
				end
				s_wait_release: begin
					// redirect and busy release on the same edge.
					if (!resolve_ack) begin
						redirect <= 1'b1;
						state <= s_idle;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	// captured branch, held until redirect.
	always_ff @(posedge clk) begin
		if (state == s_idle && branch_issue) begin
			pc_q <= inst_pc;
			target_q <= target;
			counter_q <= pred_counter;
			pattern_q <= pred_pattern;
		end
		if (state == s_wait_ack && resolve_ack) begin
			taken_q <= resolve_taken;
		end
	end

	assign busy = (state != s_idle);
	assign resolve_req = (state == s_wait_ack);
	assign resolve_pc = pc_q;

	assign commit_pattern = pattern_q;
	assign commit_counter = counter_q;
	assign commit_failure = taken_q ^ counter_q[1];

	// fetch restarts here whether or not the guess was right.
	assign redirect_addr = taken_q ? target_q : addr_t'(pc_q + 1'b1);

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  logic             imem_we,
	input  fetch_pkg::addr_t imem_waddr,
	input  fetch_pkg::inst_t imem_wdata,
	input  fetch_pkg::addr_t return_addr,
	input  logic             resolve_ack,
	input  logic             resolve_taken,
	output logic             inst_valid,
	output fetch_pkg::inst_t inst_bits,
	output fetch_pkg::addr_t inst_pc,
	output logic             inst_pred_taken,
	output logic             resolve_req,
	output fetch_pkg::addr_t resolve_pc
);
	import fetch_pkg::*;

	logic     is_jump;
	logic     is_branch;
	logic     is_jreg;
	addr_t    target;
	logic     lookup_en;
	addr_t    lookup_addr;
	counter_t pred_counter;
	pattern_t pred_pattern;
	logic     branch_issue;
	logic     busy;
	logic     commit;
	pattern_t commit_pattern;
	logic     commit_failure;
	counter_t commit_counter;
	logic     redirect;
	addr_t    redirect_addr;

	assign inst_pred_taken = pred_counter[1];

	inst_fetch u_fetch (
		.clk           (clk),
		.reset         (reset),
		.stall         (stall),
		.busy          (busy),
		.imem_we       (imem_we),
		.imem_waddr    (imem_waddr),
		.imem_wdata    (imem_wdata),
		.return_addr   (return_addr),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.is_jump       (is_jump),
		.is_branch     (is_branch),
		.is_jreg       (is_jreg),
		.target        (target),
		.pred_counter  (pred_counter),
		.inst_valid    (inst_valid),
		.inst_bits     (inst_bits),
		.inst_pc       (inst_pc),
		.lookup_en     (lookup_en),
		.lookup_addr   (lookup_addr),
		.branch_issue  (branch_issue)
	);

	inst_decode u_decode (
		.inst      (inst_bits),
		.is_jump   (is_jump),
		.is_branch (is_branch),
		.is_jreg   (is_jreg),
		.target    (target)
	);

	branch_predictor u_predictor (
		.clk            (clk),
		.reset          (reset),
		.lookup_en      (lookup_en),
		.lookup_addr    (lookup_addr),
		.pred_counter   (pred_counter),
		.pred_pattern   (pred_pattern),
		.commit         (commit),
		.commit_pattern (commit_pattern),
		.commit_failure (commit_failure),
		.commit_counter (commit_counter)
	);

	branch_resolve u_resolve (
		.clk            (clk),
		.reset          (reset),
		.branch_issue   (branch_issue),
		.inst_pc        (inst_pc),
		.target         (target),
		.pred_counter   (pred_counter),
		.pred_pattern   (pred_pattern),
		.resolve_ack    (resolve_ack),
		.resolve_taken  (resolve_taken),
		.busy           (busy),
		.resolve_req    (resolve_req),
		.resolve_pc     (resolve_pc),
		.commit         (commit),
		.commit_pattern (commit_pattern),
		.commit_failure (commit_failure),
		.commit_counter (commit_counter),
		.redirect       (redirect),
		.redirect_addr  (redirect_addr)
	);

endmodule

// ==== verification/fetch_checker.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_checker (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  logic             imem_we,
	input  fetch_pkg::addr_t imem_waddr,
	input  fetch_pkg::inst_t imem_wdata,
	input  fetch_pkg::addr_t return_addr,
	input  logic             resolve_ack,
	input  logic             resolve_taken,
	input  logic             inst_valid,
	input  fetch_pkg::inst_t inst_bits,
	input  fetch_pkg::addr_t inst_pc,
	input  logic             inst_pred_taken,
	input  logic             resolve_req,
	input  fetch_pkg::addr_t resolve_pc,
	input  int               test_num,
	input  logic             test_end,
	output int               error_count,
	output int               word_count
);
	import fetch_pkg::*;

	inst_t    mem_model [2**`FETCH_ADDR_W];
	counter_t pht_model [2**`FETCH_PAT_W];
	history_t gh;
	addr_t    pc_exp;
	logic     pending;
	logic     expect_req;
	addr_t    branch_pc;
	inst_t    branch_bits;
	logic     branch_pred;
	pattern_t branch_idx;
	pattern_t idx;
	logic     holding;
	logic     follow;
	int       since_reset;
	int       test_words;
	int       test_branches;
	int       test_errors;

	// gshare index with the history over the top address bits.
	function automatic pattern_t ref_index(input addr_t pc, input history_t h);
		pattern_t p;
		p = pattern_t'(pc);
		p[`FETCH_PAT_W-1 -: `FETCH_GH_W] = p[`FETCH_PAT_W-1 -: `FETCH_GH_W] ^ h;
		return p;
	endfunction

	function automatic counter_t ref_update(input counter_t c, input logic failure);
		if (!failure) begin
			return {c[1], 1'b1};
		end else if (c[0]) begin
			return {c[1], 1'b0};
		end
		return {~c[1], 1'b0};
	endfunction

	function automatic addr_t ref_next(input addr_t pc, input inst_t bits, input addr_t ret,
			input logic taken);
		case (bits[`FETCH_INST_W-1 -: 4])
			op_jump: return bits[`FETCH_ADDR_W-1:0];
			op_jreg: return ret;
			op_branch: return taken ? bits[`FETCH_ADDR_W-1:0] : addr_t'(pc + 1'b1);
			default: return addr_t'(pc + 1'b1);
		endcase
	endfunction

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
		error_count++;
		test_errors++;
	endtask

	task automatic problem(input string msg);
		$display("error at t=%0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	initial begin
		error_count = 0;
		word_count = 0;
		test_words = 0;
		test_branches = 0;
		test_errors = 0;
	end

	always @(posedge clk) begin
		if (imem_we) begin
			mem_model[imem_waddr] <= imem_wdata;
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			pc_exp = addr_t'(`FETCH_PC_INIT);
			gh = '0;
			for (int i = 0; i < 2**`FETCH_PAT_W; i++) begin
				pht_model[i] = '0;
			end
			pending = 1'b0;
			expect_req = 1'b0;
			holding = 1'b0;
			follow = 1'b0;
			since_reset = 0;
		end else begin
			since_reset++;
			if (since_reset == 2 && !inst_valid) begin
				problem("first word missing one cycle after reset");
			end
			if (holding && !inst_valid) begin
				problem("output word dropped while stalled");
			end
			if (follow && !inst_valid) begin
				problem("no word on the cycle after an accepted word");
			end
			holding = inst_valid && stall;
			follow = 1'b0;

			if (expect_req) begin
				if (!resolve_req) begin
					problem("resolve_req did not rise after a branch");
				end else if (resolve_pc !== branch_pc) begin
					mismatch("resolve_pc", branch_pc, resolve_pc);
				end
				expect_req = 1'b0;
			end

			// outcome is taken on the same edge as the DUT samples it.
			if (resolve_req && resolve_ack) begin
				if (!pending) begin
					problem("resolve_req without an unresolved branch");
				end else begin
					pht_model[branch_idx] = ref_update(pht_model[branch_idx],
						resolve_taken ^ branch_pred);
					gh = {gh[`FETCH_GH_W-2:0], resolve_taken};
					pc_exp = ref_next(branch_pc, branch_bits, return_addr, resolve_taken);
					pending = 1'b0;
					test_branches++;
				end
			end

			if (inst_valid && !stall) begin
				word_count++;
				test_words++;
			end
			if (inst_valid && pending) begin
				problem("word shown while a branch was unresolved");
			end else if (inst_valid) begin
				// a stalled word is compared on every cycle it is held.
				idx = ref_index(pc_exp, gh);
				if (inst_pc !== pc_exp) mismatch("inst_pc", pc_exp, inst_pc);
				if (inst_bits !== mem_model[pc_exp]) begin
					mismatch("inst_bits", mem_model[pc_exp], inst_bits);
				end
				if (inst_pred_taken !== pht_model[idx][1]) begin
					mismatch("inst_pred_taken", pht_model[idx][1], inst_pred_taken);
				end
				if (!stall && mem_model[pc_exp][`FETCH_INST_W-1 -: 4] == op_branch) begin
					pending = 1'b1;
					expect_req = 1'b1;
					branch_pc = pc_exp;
					branch_bits = mem_model[pc_exp];
					branch_pred = pht_model[idx][1];
					branch_idx = idx;
				end else if (!stall) begin
					pc_exp = ref_next(pc_exp, mem_model[pc_exp], return_addr, 1'b0);
					follow = 1'b1;
				end
			end
		end

		if (test_end) begin
			$display("test %0d: %0d words, %0d branches, %0d errors", test_num, test_words,
				test_branches, test_errors);
			test_words = 0;
			test_branches = 0;
			test_errors = 0;
		end
	end

endmodule

// ==== verification/fetch_tb.sv ====
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_tb;
	import fetch_pkg::*;

	logic  clk;
	logic  reset;
	logic  stall;
	logic  imem_we;
	addr_t imem_waddr;
	inst_t imem_wdata;
	addr_t return_addr;
	logic  resolve_ack;
	logic  resolve_taken;
	logic  inst_valid;
	inst_t inst_bits;
	addr_t inst_pc;
	logic  inst_pred_taken;
	logic  resolve_req;
	addr_t resolve_pc;
	int    test_num;
	logic  test_end;
	int    error_count;
	int    word_count;

	logic [31:0] lfsr;
	int          ack_wait;
	int          test_len [5] = '{40, 60, 120, 100, 80};

	fetch_top DUT (.*);

	fetch_checker u_checker (.*);

	always #5 clk = ~clk;

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[31]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic make_word(input int num, input addr_t a, output inst_t w);
		logic [31:0] fill;
		logic [31:0] r;
		logic [3:0]  op;
		addr_t       tgt;
		get_bits(12, fill);
		get_bits(8, r);
		tgt = r[7:0];
		op = op_plain;
		get_bits(4, r);
		case (num)
			2: op = (r[2:0] == 0) ? op_jump : (r[2:0] == 1) ? op_jreg : op_plain;
			3: op = r[3:0];
			4: op = (r[1:0] == 0) ? op_branch : op_plain;
			5: begin
				// one branch at 5 whose both paths jump back to it.
				if (a == 8'h05) begin
					op = op_branch;
					tgt = 8'h20;
				end else if (a == 8'h06 || a == 8'h20) begin
					op = op_jump;
					tgt = 8'h05;
				end
			end
			default: op = op_plain;
		endcase
		w = {op, fill[11:0], a, tgt};
	endtask

	task automatic drive_cycle(input int num);
		logic [31:0] v;
		if (num == 3 || num == 4) begin
			get_bits(2, v);
			stall = (v[1:0] == 2'b00);
		end else begin
			stall = 1'b0;
		end
		if (resolve_ack && !resolve_req) begin
			resolve_ack = 1'b0;
		end else if (resolve_req && !resolve_ack) begin
			if (ack_wait < 0) begin
				get_bits(3, v);
				ack_wait = v;
			end
			if (ack_wait == 0) begin
				get_bits(2, v);
				// mostly taken in the loop test, so the predictor saturates.
				resolve_taken = (num == 5) ? |v[1:0] : v[0];
				resolve_ack = 1'b1;
				ack_wait = -1;
			end else begin
				ack_wait--;
			end
		end
	endtask

	task automatic run_test(input int num, input int len);
		logic [31:0] v;
		inst_t       w;
		int          target;
		@(negedge clk);
		reset = 1'b1;
		stall = 1'b0;
		resolve_ack = 1'b0;
		resolve_taken = 1'b0;
		ack_wait = -1;
		test_num = num;
		get_bits(8, v);
		return_addr = v[7:0];
		for (int i = 0; i < 2**`FETCH_ADDR_W; i++) begin
			make_word(num, addr_t'(i), w);
			imem_we = 1'b1;
			imem_waddr = addr_t'(i);
			imem_wdata = w;
			@(negedge clk);
		end
		imem_we = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		target = word_count + len;
		while (word_count < target) begin
			drive_cycle(num);
			@(negedge clk);
		end
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin : watchdog
		int budget;
		budget = 0;
		foreach (test_len[i]) begin
			budget += 2**`FETCH_ADDR_W + 8 + test_len[i] * 16;
		end
		// margin of two over the worst case.
		#(budget * 10 * 2);
		$display("timeout: tests did not finish within %0d cycles", budget * 2);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		imem_we = 1'b0;
		imem_waddr = '0;
		imem_wdata = '0;
		return_addr = '0;
		resolve_ack = 1'b0;
		resolve_taken = 1'b0;
		test_num = 0;
		test_end = 1'b0;
		lfsr = 32'hfb94;
		ack_wait = -1;
		for (int t = 1; t <= 5; t++) begin
			run_test(t, test_len[t-1]);
		end
		$display("tests 5, words %0d, errors %0d", word_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
logic/fetch_pkg.sv
logic/inst_decode.sv
logic/branch_predictor.sv
logic/inst_fetch.sv
logic/branch_resolve.sv
logic/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch

export_include_dirs:
  - include

sources:
  - logic/fetch_pkg.sv
  - logic/inst_decode.sv
  - logic/branch_predictor.sv
  - logic/inst_fetch.sv
  - logic/branch_resolve.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - verification/fetch_checker.sv
      - verification/fetch_tb.sv
